// ==== src/mont_pkg.sv ====
//####################################################################
// default sizes keep the modulus at 64 bits; operands are LS word first
//####################################################################
`default_nettype none

package mont_pkg;

	localparam int word_w_default    = 16; // bits per word
	localparam int num_words_default = 4;  // words per operand

	// exponent sequencer states
	typedef enum logic [2:0] {
		idle,      // waiting for start
		wait_load, // operand words arriving
		to_mont,   // m into montgomery form
		scan_skip, // drop leading zero bits of e
		square,
		multiply,
		next_bit,  // step to the next lower bit
		from_mont  // product with 1, back to normal form
	} exp_state_e;

	// montgomery product opcodes
	typedef enum logic [1:0] {
		op_to_mont,  // m_bar = m * r2 mod n, c_bar = r mod n
		op_square,   // c_bar = c_bar * c_bar
		op_multiply, // c_bar = c_bar * m_bar
		op_from_mont // c_bar = c_bar * 1
	} mont_op_e;

endpackage

`default_nettype wire

// ==== src/operand_loader.sv ====
//####################################################################
// exactly NUM_WORDS load strobes follow each start; extra strobes dropped
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module operand_loader #(
	parameter int WORD_W    = mont_pkg::word_w_default,
	parameter int NUM_WORDS = mont_pkg::num_words_default,
	localparam int IDX_W    = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1
) (
	input  wire               clk,
	input  wire               reset,
	input  wire               start,
	input  wire  [WORD_W-1:0] n0_prime,
	input  wire               load_valid,
	input  wire  [WORD_W-1:0] m_word,
	input  wire  [WORD_W-1:0] e_word,
	input  wire  [WORD_W-1:0] n_word,
	input  wire  [WORD_W-1:0] rmodn_word,
	input  wire  [WORD_W-1:0] r2modn_word,
	input  wire  [IDX_W-1:0]  e_index,
	input  wire  [IDX_W-1:0]  word_index,
	output logic              load_done,
	output logic              busy_load,
	output logic [WORD_W-1:0] e_word_rd,
	output logic [WORD_W-1:0] m_rd,
	output logic [WORD_W-1:0] n_rd,
	output logic [WORD_W-1:0] rmodn_rd,
	output logic [WORD_W-1:0] r2modn_rd,
	output logic [WORD_W-1:0] n0_prime_rd
);

	logic [WORD_W-1:0] m_mem [NUM_WORDS];
	logic [WORD_W-1:0] e_mem [NUM_WORDS];
	logic [WORD_W-1:0] n_mem [NUM_WORDS];
	logic [WORD_W-1:0] rmodn_mem [NUM_WORDS];
	logic [WORD_W-1:0] r2modn_mem [NUM_WORDS];
	logic [IDX_W-1:0]  load_cnt; // next word slot
	logic              take_start;
	logic              take_word;

	assign take_start = start && !busy_load;
	assign take_word  = busy_load && load_valid;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy_load <= 1'b0;
			load_cnt  <= '0;
			load_done <= 1'b0;
		end else begin
			load_done <= 1'b0; // single cycle strobe
			if (take_start) begin
				busy_load <= 1'b1;
				load_cnt  <= '0;
			end else if (take_word) begin
				load_cnt <= load_cnt + 1'b1;
				if (load_cnt == IDX_W'(NUM_WORDS - 1)) begin // last word in
					busy_load <= 1'b0;
					load_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_start)
			n0_prime_rd <= n0_prime; // held for the whole operation
		if (take_word) begin
			m_mem[load_cnt]      <= m_word;
			e_mem[load_cnt]      <= e_word;
			n_mem[load_cnt]      <= n_word;
			rmodn_mem[load_cnt]  <= rmodn_word;
			r2modn_mem[load_cnt] <= r2modn_word;
		end
	end

	// combinational read ports
	assign e_word_rd = e_mem[e_index];
	assign m_rd      = m_mem[word_index];
	assign n_rd      = n_mem[word_index];
	assign rmodn_rd  = rmodn_mem[word_index];
	assign r2modn_rd = r2modn_mem[word_index];

endmodule

`default_nettype wire

// ==== src/exp_sequencer.sv ====
//####################################################################
// one op in flight at a time; e scanned msb first, one bit per cycle
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module exp_sequencer #(
	parameter int WORD_W    = mont_pkg::word_w_default,
	parameter int NUM_WORDS = mont_pkg::num_words_default,
	localparam int IDX_W    = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1
) (
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  start,
	input  wire                  load_done,
	input  wire  [WORD_W-1:0]    e_word_rd,
	input  wire                  op_done,
	output logic [IDX_W-1:0]     e_index,
	output logic                 op_start,
	output mont_pkg::mont_op_e   op,
	output logic                 busy
);

	localparam int BIT_W = (WORD_W > 1) ? $clog2(WORD_W) : 1;

	mont_pkg::exp_state_e state;
	logic [BIT_W-1:0]     bit_idx;      // bit inside current e word
	logic [IDX_W-1:0]     next_e_index;
	logic [BIT_W-1:0]     next_bit_idx;
	logic                 e_bit;
	logic                 at_lsb;       // pointer on bit 0 of word 0

	assign e_bit  = e_word_rd[bit_idx];
	assign at_lsb = (e_index == '0) && (bit_idx == '0);

	// pointer one bit lower
	always_comb begin
		next_e_index = e_index;
		next_bit_idx = bit_idx - 1'b1;
		if (bit_idx == '0) begin
			next_e_index = e_index - 1'b1; // borrow into lower word
			next_bit_idx = BIT_W'(WORD_W - 1);
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state    <= mont_pkg::idle;
			busy     <= 1'b0;
			op_start <= 1'b0;
			op       <= mont_pkg::op_to_mont;
			e_index  <= '0;
			bit_idx  <= '0;
		end else begin
			op_start <= 1'b0;
			case (state)
				mont_pkg::idle: if (start) begin
					busy  <= 1'b1;
					state <= mont_pkg::wait_load;
				end
				mont_pkg::wait_load: if (load_done) begin
					op       <= mont_pkg::op_to_mont;
					op_start <= 1'b1;
					e_index  <= IDX_W'(NUM_WORDS - 1); // start at msb of e
					bit_idx  <= BIT_W'(WORD_W - 1);
					state    <= mont_pkg::to_mont;
				end
				mont_pkg::to_mont: if (op_done)
					state <= mont_pkg::scan_skip;
				mont_pkg::scan_skip: begin
					if (e_bit) begin // top set bit, c_bar is r mod n so no square
						op       <= mont_pkg::op_multiply;
						op_start <= 1'b1;
						state    <= mont_pkg::multiply;
					end else if (at_lsb) begin // e == 0
						op       <= mont_pkg::op_from_mont;
						op_start <= 1'b1;
						state    <= mont_pkg::from_mont;
					end else begin
						e_index <= next_e_index;
						bit_idx <= next_bit_idx;
					end
				end
				mont_pkg::square: if (op_done) begin
					if (e_bit) begin
						op       <= mont_pkg::op_multiply;
						op_start <= 1'b1;
						state    <= mont_pkg::multiply;
					end else
						state <= mont_pkg::next_bit;
				end
				mont_pkg::multiply: if (op_done)
					state <= mont_pkg::next_bit;
				mont_pkg::next_bit: begin
					op_start <= 1'b1;
					if (at_lsb) begin
						op    <= mont_pkg::op_from_mont;
						state <= mont_pkg::from_mont;
					end else begin
						op      <= mont_pkg::op_square;
						e_index <= next_e_index;
						bit_idx <= next_bit_idx;
						state   <= mont_pkg::square;
					end
				end
				mont_pkg::from_mont: if (op_done) begin
					busy  <= 1'b0; // result taken by unloader this edge
					state <= mont_pkg::idle;
				end
				default: state <= mont_pkg::idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/mont_mul.sv ====
//####################################################################
// needs odd n and operands below n; results fully reduced below n
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module mont_mul #(
	parameter int WORD_W    = mont_pkg::word_w_default,
	parameter int NUM_WORDS = mont_pkg::num_words_default,
	localparam int IDX_W    = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1
) (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          op_start,
	input  wire mont_pkg::mont_op_e      op,
	input  wire  [WORD_W-1:0]            m_rd,
	input  wire  [WORD_W-1:0]            n_rd,
	input  wire  [WORD_W-1:0]            rmodn_rd,
	input  wire  [WORD_W-1:0]            r2modn_rd,
	input  wire  [WORD_W-1:0]            n0_prime_rd,
	output logic [IDX_W-1:0]             word_index,
	output logic                         op_done,
	output logic                         result_ready,
	output logic [WORD_W*NUM_WORDS-1:0]  result_bus
);

	localparam int MAC_W = 2 * WORD_W;

	typedef enum logic [2:0] {
		ph_idle, ph_mul, ph_top, ph_quot, ph_red, ph_fold1, ph_fold2, ph_sub
	} phase_e;

	phase_e             phase;
	mont_pkg::mont_op_e op_r;
	logic               step;                // 0 feeds the mac, 1 stores it
	logic [IDX_W-1:0]   i_cnt, j_cnt;        // outer and inner word
	logic               i_last, j_last;
	logic [WORD_W-1:0]  c_bar [NUM_WORDS];
	logic [WORD_W-1:0]  m_bar [NUM_WORDS];
	logic [WORD_W-1:0]  v [NUM_WORDS+2];     // running sum, two spare top words
	logic [WORD_W-1:0]  diff [NUM_WORDS];    // v - n words
	logic [WORD_W-1:0]  fin [NUM_WORDS];
	logic [WORD_W-1:0]  carry, q, x_word, y_word;
	logic [WORD_W-1:0]  mac_x, mac_y, mac_z, mac_cin;
	logic [MAC_W-1:0]   mac_r;               // registered multiply-add
	logic [WORD_W:0]    sub_full;
	logic               borrow, use_diff, first_row;

	assign word_index = j_cnt; // every loader word follows the inner index
	assign i_last     = (i_cnt == IDX_W'(NUM_WORDS - 1));
	assign j_last     = (j_cnt == IDX_W'(NUM_WORDS - 1));
	assign first_row  = (op_r == mont_pkg::op_to_mont) && (i_cnt == '0);

	always_comb begin
		case (op_r)
			mont_pkg::op_to_mont:  begin x_word = m_bar[i_cnt]; y_word = r2modn_rd; end
			mont_pkg::op_multiply: begin x_word = c_bar[i_cnt]; y_word = m_bar[j_cnt]; end
			mont_pkg::op_from_mont: begin
				x_word = (i_cnt == '0) ? WORD_W'(1) : '0; // the constant 1
				y_word = c_bar[j_cnt];
			end
			default:               begin x_word = c_bar[i_cnt]; y_word = c_bar[j_cnt]; end
		endcase
	end

	// mac operand select per phase
	always_comb begin
		mac_x   = '0;
		mac_y   = '0;
		mac_z   = '0;
		mac_cin = '0;
		case (phase)
			ph_mul: begin
				mac_x   = x_word;
				mac_y   = y_word;
				mac_z   = v[j_cnt];
				mac_cin = (j_cnt == '0) ? '0 : carry;
			end
			ph_top:   begin mac_z = v[NUM_WORDS]; mac_cin = carry; end
			ph_quot:  begin mac_x = v[0]; mac_y = n0_prime_rd; end // low word only
			ph_red: begin
				mac_x   = q;
				mac_y   = n_rd;
				mac_z   = v[j_cnt];
				mac_cin = (j_cnt == '0) ? '0 : carry;
			end
			ph_fold1: begin mac_z = v[NUM_WORDS]; mac_cin = carry; end
			ph_fold2: begin mac_z = v[NUM_WORDS+1]; mac_cin = carry; end
			default: ;
		endcase
	end

	// word-serial v - n, final select on the last word
	always_comb begin
		sub_full = {1'b0, v[j_cnt]} - {1'b0, n_rd} - {{WORD_W{1'b0}}, borrow};
		use_diff = (v[NUM_WORDS] != '0) || !sub_full[WORD_W]; // v >= n
		for (int w = 0; w < NUM_WORDS; w++) begin
			if (!use_diff)
				fin[w] = v[w];
			else if (w == NUM_WORDS - 1)
				fin[w] = sub_full[WORD_W-1:0];
			else
				fin[w] = diff[w];
			result_bus[w*WORD_W +: WORD_W] = c_bar[w];
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase        <= ph_idle;
			op_r         <= mont_pkg::op_to_mont;
			step         <= 1'b0;
			i_cnt        <= '0;
			j_cnt        <= '0;
			op_done      <= 1'b0;
			result_ready <= 1'b0;
		end else begin
			op_done      <= 1'b0;
			result_ready <= 1'b0;
			if (phase == ph_idle) begin
				if (op_start) begin
					op_r  <= op;
					phase <= ph_mul;
				end
			end else if (phase == ph_sub) begin
				j_cnt <= j_last ? '0 : j_cnt + 1'b1;
				if (j_last) begin // result written this edge
					phase        <= ph_idle;
					op_done      <= 1'b1;
					result_ready <= (op_r == mont_pkg::op_from_mont);
				end
			end else if (!step)
				step <= 1'b1;
			else begin
				step <= 1'b0;
				case (phase)
					ph_mul, ph_red: begin
						j_cnt <= j_last ? '0 : j_cnt + 1'b1;
						if (j_last)
							phase <= (phase == ph_mul) ? ph_top : ph_fold1;
					end
					ph_top:   phase <= ph_quot;
					ph_quot:  phase <= ph_red;
					ph_fold1: phase <= ph_fold2;
					ph_fold2: begin
						i_cnt <= i_last ? '0 : i_cnt + 1'b1;
						phase <= i_last ? ph_sub : ph_mul;
					end
					default:  phase <= ph_idle;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (phase == ph_idle && op_start) begin
			for (int w = 0; w < NUM_WORDS + 2; w++)
				v[w] <= '0;
			if (op == mont_pkg::op_to_mont)
				m_bar[0] <= m_rd; // outer word 0 needed before the copy row
		end
		if (phase != ph_idle && phase != ph_sub && !step)
			mac_r <= MAC_W'(mac_x) * MAC_W'(mac_y) + MAC_W'(mac_z) + MAC_W'(mac_cin);
		if (step) begin
			case (phase)
				ph_mul: begin
					v[j_cnt] <= mac_r[WORD_W-1:0];
					carry    <= mac_r[MAC_W-1:WORD_W];
					if (first_row) begin // copy m, preset c_bar to r mod n
						m_bar[j_cnt] <= m_rd;
						c_bar[j_cnt] <= rmodn_rd;
					end
				end
				ph_top: begin
					v[NUM_WORDS]   <= mac_r[WORD_W-1:0];
					v[NUM_WORDS+1] <= mac_r[MAC_W-1:WORD_W];
				end
				ph_quot: q <= mac_r[WORD_W-1:0];
				ph_red: begin
					if (j_cnt != '0)
						v[j_cnt - 1'b1] <= mac_r[WORD_W-1:0]; // shift down one word
					carry <= mac_r[MAC_W-1:WORD_W];
				end
				ph_fold1: begin
					v[NUM_WORDS-1] <= mac_r[WORD_W-1:0];
					carry          <= mac_r[MAC_W-1:WORD_W];
				end
				ph_fold2: begin
					v[NUM_WORDS] <= mac_r[WORD_W-1:0];
					borrow       <= 1'b0; // ready for subtract pass
				end
				default: ;
			endcase
		end
		if (phase == ph_sub) begin
			diff[j_cnt] <= sub_full[WORD_W-1:0];
			borrow      <= sub_full[WORD_W];
			if (j_last) begin
				for (int w = 0; w < NUM_WORDS; w++) begin
					if (op_r == mont_pkg::op_to_mont)
						m_bar[w] <= fin[w];
					else
						c_bar[w] <= fin[w];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/result_unloader.sv ====
//####################################################################
// no back-pressure; words leave on consecutive cycles, LS word first
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module result_unloader #(
	parameter int WORD_W    = mont_pkg::word_w_default,
	parameter int NUM_WORDS = mont_pkg::num_words_default,
	localparam int IDX_W    = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1
) (
	input  wire                         clk,
	input  wire                         reset,
	input  wire                         result_ready,
	input  wire  [WORD_W*NUM_WORDS-1:0] result_bus,
	output logic                        res_valid,
	output logic [WORD_W-1:0]           res_word
);

	logic [WORD_W*NUM_WORDS-1:0] res_buf; // private copy, frees mont_mul
	logic [IDX_W-1:0]            out_cnt;
	logic                        out_last;

	assign out_last = (out_cnt == IDX_W'(NUM_WORDS - 1));
	assign res_word = res_buf[WORD_W-1:0];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			res_valid <= 1'b0;
			out_cnt   <= '0;
		end else if (result_ready) begin
			res_valid <= 1'b1;
			out_cnt   <= '0;
		end else if (res_valid) begin
			res_valid <= !out_last;
			out_cnt   <= out_last ? '0 : out_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (result_ready)
			res_buf <= result_bus;
		else if (res_valid)
			res_buf <= res_buf >> WORD_W; // next word to the bottom
	end

endmodule

`default_nettype wire

// ==== src/mod_exp_top.sv ====
//####################################################################
// n odd and > 1, m < n; r mod n, r2 mod n and n0_prime come from the user
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module mod_exp_top #(
	parameter int WORD_W    = mont_pkg::word_w_default,
	parameter int NUM_WORDS = mont_pkg::num_words_default
) (
	input  wire               clk,
	input  wire               reset,
	input  wire               start,
	input  wire  [WORD_W-1:0] n0_prime,
	input  wire               load_valid,
	input  wire  [WORD_W-1:0] m_word,
	input  wire  [WORD_W-1:0] e_word,
	input  wire  [WORD_W-1:0] n_word,
	input  wire  [WORD_W-1:0] rmodn_word,
	input  wire  [WORD_W-1:0] r2modn_word,
	output logic              busy,
	output logic              res_valid,
	output logic [WORD_W-1:0] res_word
);

	localparam int IDX_W = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;

	wire                        start_ok;     // start outside busy
	wire                        busy_load, seq_busy, load_done;
	wire                        op_start, op_done, result_ready;
	wire mont_pkg::mont_op_e    op;
	wire [IDX_W-1:0]            e_index, word_index;
	wire [WORD_W-1:0]           e_word_rd, m_rd, n_rd, rmodn_rd, r2modn_rd, n0_prime_rd;
	wire [WORD_W*NUM_WORDS-1:0] result_bus;

	assign busy     = seq_busy | busy_load;
	assign start_ok = start & ~busy;

	operand_loader #(.WORD_W(WORD_W), .NUM_WORDS(NUM_WORDS)) operand_loader_inst (
		.clk(clk), .reset(reset), .start(start_ok), .n0_prime(n0_prime),
		.load_valid(load_valid), .m_word(m_word), .e_word(e_word), .n_word(n_word),
		.rmodn_word(rmodn_word), .r2modn_word(r2modn_word),
		.e_index(e_index), .word_index(word_index),
		.load_done(load_done), .busy_load(busy_load), .e_word_rd(e_word_rd),
		.m_rd(m_rd), .n_rd(n_rd), .rmodn_rd(rmodn_rd), .r2modn_rd(r2modn_rd),
		.n0_prime_rd(n0_prime_rd)
	);

	exp_sequencer #(.WORD_W(WORD_W), .NUM_WORDS(NUM_WORDS)) exp_sequencer_inst (
		.clk(clk), .reset(reset), .start(start_ok), .load_done(load_done),
		.e_word_rd(e_word_rd), .op_done(op_done),
		.e_index(e_index), .op_start(op_start), .op(op), .busy(seq_busy)
	);

	mont_mul #(.WORD_W(WORD_W), .NUM_WORDS(NUM_WORDS)) mont_mul_inst (
		.clk(clk), .reset(reset), .op_start(op_start), .op(op),
		.m_rd(m_rd), .n_rd(n_rd), .rmodn_rd(rmodn_rd), .r2modn_rd(r2modn_rd),
		.n0_prime_rd(n0_prime_rd), .word_index(word_index),
		.op_done(op_done), .result_ready(result_ready), .result_bus(result_bus)
	);

	result_unloader #(.WORD_W(WORD_W), .NUM_WORDS(NUM_WORDS)) result_unloader_inst (
		.clk(clk), .reset(reset), .result_ready(result_ready), .result_bus(result_bus),
		.res_valid(res_valid), .res_word(res_word)
	);

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
//####################################################################
// free-running clock; reset released 1 ns after the last reset edge
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0; // off the edge, like the stimulus
	end

endmodule

`default_nettype wire

// ==== tb/mod_exp_props.sv ====
//####################################################################
// bound into mod_exp_top; op_start and op_done are its internal wires
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module mod_exp_props #(
	parameter int NUM_WORDS = mont_pkg::num_words_default
) (
	input wire clk,
	input wire reset,
	input wire busy,
	input wire res_valid,
	input wire op_start,
	input wire op_done
);

	int fail_count = 0; // failed assertion count

	// one unbroken run per result
	assert property (@(posedge clk) disable iff (reset)
		$rose(res_valid) |-> res_valid [*NUM_WORDS] ##1 !res_valid)
		else begin
			fail_count++;
			$error("res_valid run is not NUM_WORDS long");
		end

	assert property (@(posedge clk) $fell(reset) |-> !busy)
		else begin
			fail_count++;
			$error("busy high right after reset");
		end

	// no second op until the product is done
	assert property (@(posedge clk) disable iff (reset)
		op_start |=> (!op_start until op_done))
		else begin
			fail_count++;
			$error("op_start while mont_mul is working");
		end

	assert property (@(posedge clk) reset |-> !res_valid)
		else begin
			fail_count++;
			$error("res_valid high during reset");
		end

endmodule

`default_nettype wire

// ==== tb/mod_exp_tb.sv ====
//####################################################################
// model in 128-bit math, so WORD_W * NUM_WORDS must stay at or below 64
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module mod_exp_tb;

	localparam int WORD_W     = mont_pkg::word_w_default;
	localparam int NUM_WORDS  = mont_pkg::num_words_default;
	localparam int OP_W       = WORD_W * NUM_WORDS;
	localparam int NUM_RANDOM = 12;
	localparam int NUM_TESTS  = NUM_RANDOM + 5; // five directed cases first
	localparam int PROD_CYC   = NUM_WORDS * 2 * (2 * NUM_WORDS + 4) + NUM_WORDS + 4;
	localparam int TEST_CYC   = (2 * OP_W + 2) * PROD_CYC + 3 * OP_W + 9 * NUM_WORDS + 32;
	localparam longint WATCHDOG_NS = longint'(NUM_TESTS + 2) * TEST_CYC * 10;

	wire               clk, reset, busy, res_valid;
	wire  [WORD_W-1:0] res_word;
	logic              start, load_valid;
	logic [WORD_W-1:0] n0_prime, m_word, e_word, n_word, rmodn_word, r2modn_word;
	logic [31:0]       lfsr;
	logic [OP_W-1:0]   exp_q [$]; // expected results in issue order
	logic [OP_W-1:0]   cur_exp;
	logic [127:0]      n, m, e, gap_unused;
	int                mismatch_count, other_count, issued, results_seen, word_cnt;
	int                assert_count;

	tb_clock_gen tb_clock_gen_inst (.clk(clk), .reset(reset));

	mod_exp_top #(.WORD_W(WORD_W), .NUM_WORDS(NUM_WORDS)) mod_exp_top_inst (
		.clk(clk), .reset(reset), .start(start), .n0_prime(n0_prime),
		.load_valid(load_valid), .m_word(m_word), .e_word(e_word), .n_word(n_word),
		.rmodn_word(rmodn_word), .r2modn_word(r2modn_word),
		.busy(busy), .res_valid(res_valid), .res_word(res_word)
	);

	bind mod_exp_top mod_exp_props #(.NUM_WORDS(NUM_WORDS)) mod_exp_props_inst (
		.clk(clk), .reset(reset), .busy(busy), .res_valid(res_valid),
		.op_start(op_start), .op_done(op_done)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // galois form shifting right
	endfunction

	task automatic draw_bits(input int nbits, output logic [127:0] val);
		val = '0;
		for (int b = 0; b < nbits; b++) begin
			val[b] = lfsr[0];
			lfsr   = lfsr_next(lfsr); // one step per bit
		end
	endtask

	// -1/n mod 2^WORD_W by newton iteration
	function automatic logic [WORD_W-1:0] neg_inverse(input logic [63:0] nv);
		logic [63:0] x;
		x = nv; // right to 3 bits for odd n
		for (int k = 0; k < 6; k++)
			x = x * (64'd2 - nv * x);
		return WORD_W'(-x);
	endfunction

	function automatic logic [127:0] mod_pow(input logic [127:0] b, ev, nv);
		logic [127:0] r;
		r = 128'd1 % nv;
		for (int i = OP_W - 1; i >= 0; i--) begin
			r = (r * r) % nv;
			if (ev[i])
				r = (r * b) % nv;
		end
		return r;
	endfunction

	task automatic check_value(input logic [127:0] got, expected, input string what);
		if (got !== expected) begin
			mismatch_count++;
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, expected);
		end
	endtask

	task automatic wait_cycle();
		@(posedge clk);
		#1; // drive off the edge
	endtask

	task automatic draw_modulus(output logic [127:0] nv);
		draw_bits(OP_W, nv);
		nv[OP_W-1] = 1'b1; // full width
		nv[0]      = 1'b1; // odd
	endtask

	task automatic run_test(input logic [127:0] mv, ev, nv, expected);
		logic [127:0] rmodn, r2modn, gap;
		rmodn  = (128'd1 << OP_W) % nv;
		r2modn = (rmodn * rmodn) % nv;
		exp_q.push_back(OP_W'(expected));
		while (busy)
			wait_cycle();
		start    = 1'b1;
		n0_prime = neg_inverse(64'(nv));
		wait_cycle();
		start = 1'b0;
		for (int w = 0; w < NUM_WORDS; w++) begin
			draw_bits(3, gap); // idle cycles before this word
			repeat (int'(gap)) wait_cycle();
			load_valid  = 1'b1;
			m_word      = mv[w*WORD_W +: WORD_W];
			e_word      = ev[w*WORD_W +: WORD_W];
			n_word      = nv[w*WORD_W +: WORD_W];
			rmodn_word  = rmodn[w*WORD_W +: WORD_W];
			r2modn_word = r2modn[w*WORD_W +: WORD_W];
			wait_cycle();
			load_valid = 1'b0;
		end
		issued++;
	endtask

	task automatic wait_for_results(input int count, input int limit);
		int cycles;
		cycles = 0;
		while (results_seen < count && cycles < limit) begin
			wait_cycle();
			cycles++;
		end
		if (results_seen < count) begin
			other_count++;
			$display("error at %0t ns: only %0d of %0d results came back", $time,
				results_seen, count);
		end
	endtask

	// result words sampled mid-cycle in LS word order
	always @(negedge clk) begin
		if (!reset && res_valid) begin
			if (word_cnt == 0) begin
				if (exp_q.size() == 0) begin
					other_count++;
					$display("error at %0t ns: result with no operation outstanding", $time);
				end else
					cur_exp = exp_q.pop_front();
				check_value(128'(busy), 128'd0, "busy on first result word");
			end
			check_value(128'(res_word), 128'(cur_exp[word_cnt*WORD_W +: WORD_W]),
				$sformatf("result %0d word %0d", results_seen, word_cnt));
			word_cnt++;
			if (word_cnt == NUM_WORDS) begin
				word_cnt = 0;
				results_seen++;
			end
		end else if (word_cnt != 0) begin
			other_count++;
			$display("error at %0t ns: result run broke off after %0d words", $time, word_cnt);
			word_cnt = 0;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t ns with %0d of %0d results seen", $time,
			results_seen, issued);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		start       = 1'b0;
		load_valid  = 1'b0;
		n0_prime    = '0;
		m_word      = '0;
		e_word      = '0;
		n_word      = '0;
		rmodn_word  = '0;
		r2modn_word = '0;
		lfsr        = 32'h1e0dbb27;
		mismatch_count = 0;
		other_count    = 0;
		issued         = 0;
		results_seen   = 0;
		word_cnt       = 0;
		assert_count   = 0;
		@(negedge reset);
		wait_cycle();

		draw_modulus(n);
		draw_bits(OP_W, m);
		m = m % n;
		run_test(m, 128'd0, n, 128'd1); // e = 0
		wait_for_results(issued, TEST_CYC);
		run_test(m, 128'd1, n, m);
		wait_for_results(issued, TEST_CYC);
		run_test(m, 128'd2, n, (m * m) % n);
		wait_for_results(issued, TEST_CYC);
		draw_bits(OP_W, e);
		e[0] = 1'b1; // nonzero
		run_test(128'd0, e, n, 128'd0);
		wait_for_results(issued, TEST_CYC);
		run_test(128'd1, e, n, 128'd1);
		wait_for_results(issued, TEST_CYC);

		// next start lands while the last result streams
		for (int t = 0; t < NUM_RANDOM; t++) begin
			draw_modulus(n);
			draw_bits(OP_W, m);
			m = m % n;
			draw_bits(6, gap_unused); // random exponent width
			draw_bits(OP_W, e);
			e = e >> gap_unused[5:0];
			run_test(m, e, n, mod_pow(m, e, n));
		end
		wait_for_results(issued, 2 * TEST_CYC);

		assert_count = mod_exp_top_inst.mod_exp_props_inst.fail_count;
		$display("summary: %0d results, %0d mismatches, %0d other errors, %0d assertion errors",
			results_seen, mismatch_count, other_count, assert_count);
		if (mismatch_count == 0 && other_count == 0 && assert_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mod_exp.f ====
src/mont_pkg.sv
src/operand_loader.sv
src/exp_sequencer.sv
src/mont_mul.sv
src/result_unloader.sv
src/mod_exp_top.sv
tb/tb_clock_gen.sv
tb/mod_exp_props.sv
tb/mod_exp_tb.sv

// ==== Bender.yml ====
package:
  name: mod_exp

sources:
  - src/mont_pkg.sv
  - src/operand_loader.sv
  - src/exp_sequencer.sv
  - src/mont_mul.sv
  - src/result_unloader.sv
  - src/mod_exp_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/mod_exp_props.sv
      - tb/mod_exp_tb.sv
